// File: all.f
design/fir_decim_pkg.sv
design/dp_ram.sv
design/dsp_mac.sv
design/fir_decim_seq.sv
design/out_round_sat.sv
design/fir_decim_top.sv
verif/fir_decim_chk.sv
verif/fir_decim_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decimating FIR testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module fir_decim_tb -Mdir obj_dir -f all.f \
    || { echo "Build failed"; exit 1; }

./obj_dir/Vfir_decim_tb | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }

// File: verif/fir_decim_tb.sv
// Decimating FIR testbench
`default_nettype none

module fir_decim_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import fir_decim_pkg::*;

    localparam int ROWS      = 23;
    localparam int SAT_ROW   = 14;
    localparam int SPACING   = 64;
    localparam int LATENCY   = 41;
    localparam int OUT_WAIT  = 60;
    localparam int INIT_WAIT = 100;
    localparam int SMAX      = 2 ** (SAMPLE_W - 1) - 1;
    localparam int SMIN      = -(2 ** (SAMPLE_W - 1));

    logic                       clk;
    logic                       reset;
    logic                       sample_in_rdy;
    logic signed [SAMPLE_W-1:0] sample_in_l;
    logic signed [SAMPLE_W-1:0] sample_in_r;
    logic                       sample_out_rdy;
    logic signed [SAMPLE_W-1:0] sample_out_l;
    logic signed [SAMPLE_W-1:0] sample_out_r;
    logic                       overrun;
    logic                       init_done;

    // Stimulus table, eight input pairs and one output pair per row
    logic signed [SAMPLE_W-1:0] stim_l [ROWS][DECIM];
    logic signed [SAMPLE_W-1:0] stim_r [ROWS][DECIM];
    logic signed [SAMPLE_W-1:0] exp_l  [ROWS];
    logic signed [SAMPLE_W-1:0] exp_r  [ROWS];
    logic                       extra  [ROWS];
    string                      kind   [ROWS];

    int seed;
    int err_cnt;
    int pass_cnt;
    int overrun_cnt = 0;
    bit timed_out;

    fir_decim_top u_dut (
        .clk(clk), .reset(reset), .sample_in_rdy(sample_in_rdy),
        .sample_in_l(sample_in_l), .sample_in_r(sample_in_r),
        .sample_out_rdy(sample_out_rdy), .sample_out_l(sample_out_l),
        .sample_out_r(sample_out_r), .overrun(overrun), .init_done(init_done)
    );

    bind fir_decim_seq fir_decim_chk u_chk (
        .clk(clk), .reset(reset), .acc_valid(acc_valid), .xbuf_wr(xbuf_wr),
        .xbuf_wr_addr(xbuf_wr_addr), .xbuf_rd(xbuf_rd), .xbuf_rd_addr(xbuf_rd_addr),
        .opmode(opmode), .init_done(init_done)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (overrun) begin
            overrun_cnt++;
        end
    end

    // ----------------------------------------------------------------------
    // Reference model over the whole accepted input history
    // ----------------------------------------------------------------------
    function automatic logic signed [SAMPLE_W-1:0] model_out(input int row, input bit right);
        longint sum;
        longint x;
        int     n;
        sum = 0;
        for (int i = 0; i < TAP_CNT; i++) begin
            n = row * DECIM + DECIM - 1 - i;
            x = 0;
            if (n >= 0) begin
                x = right ? stim_r[n / DECIM][n % DECIM] : stim_l[n / DECIM][n % DECIM];
            end
            sum += longint'(FIR_COEFS[i]) * x;
        end
        sum = (sum + (longint'(1) <<< (OUT_SHIFT - 1))) >>> OUT_SHIFT;
        if (sum > SMAX) begin
            sum = SMAX;
        end else if (sum < SMIN) begin
            sum = SMIN;
        end
        return SAMPLE_W'(sum);
    endfunction

    task automatic build_table();
        int tap;
        seed = 32'hf986_4fec;
        for (int r = 0; r < ROWS; r++) begin
            extra[r] = 1'b0;
            for (int s = 0; s < DECIM; s++) begin
                tap = SAT_ROW * DECIM + DECIM - 1 - (r * DECIM + s);
                if (r < 5) begin
                    kind[r] = "impulse";
                    stim_l[r][s] = (r == 0 && s == 0) ? SAMPLE_W'(SMAX) : '0;
                    stim_r[r][s] = '0;
                end else if (r < 10) begin
                    kind[r] = "dc";
                    stim_l[r][s] = SAMPLE_W'(50000);
                    stim_r[r][s] = SAMPLE_W'(-70000);
                end else if (r <= SAT_ROW) begin
                    // Signs follow the taps so the last row lands on the limits
                    kind[r] = "saturation";
                    if (tap < TAP_CNT && FIR_COEFS[tap] < 0) begin
                        stim_l[r][s] = SAMPLE_W'(SMIN);
                    end else begin
                        stim_l[r][s] = SAMPLE_W'(SMAX);
                    end
                    stim_r[r][s] = ~stim_l[r][s];
                end else begin
                    kind[r] = "random";
                    stim_l[r][s] = SAMPLE_W'($random(seed));
                    stim_r[r][s] = SAMPLE_W'($random(seed));
                end
            end
        end
        extra[18] = 1'b1;
        extra[21] = 1'b1;
        kind[18]  = "random overrun";
        kind[21]  = "random overrun";
        for (int r = 0; r < ROWS; r++) begin
            exp_l[r] = model_out(r, 1'b0);
            exp_r[r] = model_out(r, 1'b1);
        end
    endtask

    task automatic wait_init();
        int cycles;
        cycles = 0;
        while (!init_done && cycles < INIT_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!init_done) begin
            $display("Timeout: init_done did not rise within %0d cycles", INIT_WAIT);
            timed_out = 1'b1;
        end else begin
            $display("Init: init_done high after %0d cycles", cycles);
        end
    endtask

    task automatic send_pair(input logic signed [SAMPLE_W-1:0] l,
                             input logic signed [SAMPLE_W-1:0] r);
        @(posedge clk);
        sample_in_rdy <= 1'b1;
        sample_in_l   <= l;
        sample_in_r   <= r;
        @(posedge clk);
        sample_in_rdy <= 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // One table row: eight strobes, then the output pair
    // ----------------------------------------------------------------------
    task automatic run_row(input int row);
        int                         cycles;
        int                         ovr_start;
        int                         row_err;
        bit                         seen;
        logic signed [SAMPLE_W-1:0] got_l;
        logic signed [SAMPLE_W-1:0] got_r;
        ovr_start = overrun_cnt;
        row_err   = 0;
        for (int s = 0; s < DECIM; s++) begin
            send_pair(stim_l[row][s], stim_r[row][s]);
            if (s < DECIM - 1) begin
                repeat (SPACING - 2) @(posedge clk);
            end
        end
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < OUT_WAIT) begin
            @(posedge clk);
            cycles++;
            if (extra[row] && cycles == 10) begin
                sample_in_rdy <= 1'b1;
                sample_in_l   <= 18'sh12345;
                sample_in_r   <= 18'sh2abcd;
            end else begin
                sample_in_rdy <= 1'b0;
            end
            @(negedge clk);
            seen = sample_out_rdy;
        end
        if (!seen) begin
            $display("Timeout: no sample_out_rdy within %0d cycles in row %0d", OUT_WAIT, row);
            timed_out = 1'b1;
        end else begin
            got_l = sample_out_l;
            got_r = sample_out_r;
            if (got_l !== exp_l[row]) begin
                $display("Fail row %0d sample_out_l: got %h expected %h", row, got_l, exp_l[row]);
                row_err++;
            end
            if (got_r !== exp_r[row]) begin
                $display("Fail row %0d sample_out_r: got %h expected %h", row, got_r, exp_r[row]);
                row_err++;
            end
            if (cycles != LATENCY) begin
                $display("Fail row %0d latency: got %h expected %h", row, cycles, LATENCY);
                row_err++;
            end
            // Output strobe lasts a single cycle
            @(negedge clk);
            if (sample_out_rdy !== 1'b0) begin
                $display("Fail row %0d sample_out_rdy: got %h expected %h",
                         row, sample_out_rdy, 1'b0);
                row_err++;
            end
            repeat (SPACING - 3 - cycles) @(negedge clk);
            if (overrun_cnt - ovr_start != int'(extra[row])) begin
                $display("Fail row %0d overrun pulses: got %h expected %h",
                         row, overrun_cnt - ovr_start, int'(extra[row]));
                row_err++;
            end
            err_cnt += row_err;
            if (row_err == 0) begin
                pass_cnt++;
            end
            $display("Row %0d %s: %s, out l=%h r=%h", row, kind[row],
                     (row_err == 0) ? "ok" : "mismatch", got_l, got_r);
        end
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        sample_in_rdy = 1'b0;
        sample_in_l   = '0;
        sample_in_r   = '0;
        err_cnt       = 0;
        pass_cnt      = 0;
        timed_out     = 1'b0;
        build_table();
        repeat (16) @(posedge clk);
        if (sample_out_rdy || overrun || init_done) begin
            $display("Outputs not held low during reset");
            err_cnt++;
        end
        reset <= 1'b0;
        wait_init();
        for (int row = 0; row < ROWS && !timed_out; row++) begin
            run_row(row);
        end
        $display("Rows passed %0d of %0d, check errors %0d", pass_cnt, ROWS, err_cnt);
        if (timed_out || err_cnt != 0) begin
            $display("*** TEST FAILED ***");
        end else begin
            $display("*** TEST PASSED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/fir_decim_chk.sv
// Sequencer control assertions
`default_nettype none

module fir_decim_chk (
    input wire logic                               clk,
    input wire logic                               reset,
    input wire logic                               acc_valid,
    input wire logic                               xbuf_wr,
    input wire logic [fir_decim_pkg::TAP_W-1:0]    xbuf_wr_addr,
    input wire logic                               xbuf_rd,
    input wire logic [fir_decim_pkg::TAP_W-1:0]    xbuf_rd_addr,
    input wire logic [fir_decim_pkg::OPMODE_W-1:0] opmode,
    input wire logic                               init_done
);

    timeunit 1ns;
    timeprecision 1ps;

    import fir_decim_pkg::*;

    a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        acc_valid |=> !acc_valid)
        else $error("acc_valid high for more than one cycle");

    a_wr_addr_range: assert property (@(posedge clk) disable iff (reset)
        xbuf_wr |-> (xbuf_wr_addr < TAP_CNT))
        else $error("delay-line write address out of range");

    a_rd_addr_range: assert property (@(posedge clk) disable iff (reset)
        xbuf_rd |-> (xbuf_rd_addr < TAP_CNT))
        else $error("delay-line read address out of range");

    a_no_mac_in_init: assert property (@(posedge clk) disable iff (reset)
        !init_done |-> (opmode == OP_NOP))
        else $error("DSP opmode active before init_done");

endmodule

`default_nettype wire

// File: design/fir_decim_top.sv
// Stereo decimating FIR top level
`default_nettype none

module fir_decim_top (
    input  wire logic                                       clk,
    input  wire logic                                       reset,
    input  wire logic                                       sample_in_rdy,
    input  wire logic signed [fir_decim_pkg::SAMPLE_W-1:0] sample_in_l,
    input  wire logic signed [fir_decim_pkg::SAMPLE_W-1:0] sample_in_r,
    output logic                                            sample_out_rdy,
    output logic      signed [fir_decim_pkg::SAMPLE_W-1:0] sample_out_l,
    output logic      signed [fir_decim_pkg::SAMPLE_W-1:0] sample_out_r,
    output logic                                            overrun,
    output logic                                            init_done
);

    import fir_decim_pkg::*;

    logic                       xbuf_wr, xbuf_rd, acc_valid;
    logic [TAP_W-1:0]           xbuf_wr_addr, xbuf_rd_addr;
    logic [2*SAMPLE_W-1:0]      xbuf_wr_data, xbuf_rd_data;
    logic [OPMODE_W-1:0]        opmode;
    logic signed [SAMPLE_W-1:0] coef, samp_l, samp_r;
    logic signed [ACC_W-1:0]    acc_l, acc_r;

    fir_decim_seq u_seq (
        .clk, .reset, .sample_in_rdy, .sample_in_l, .sample_in_r,
        .xbuf_wr, .xbuf_wr_addr, .xbuf_wr_data, .xbuf_rd, .xbuf_rd_addr,
        .xbuf_rd_data, .opmode, .coef, .samp_l, .samp_r,
        .acc_valid, .overrun, .init_done
    );

    // Left sample in the upper half of each word
    dp_ram #(.DATA_W(2 * SAMPLE_W), .ADDR_W(TAP_W), .DEPTH(TAP_CNT)) u_xbuf (
        .clk, .wr(xbuf_wr), .wr_addr(xbuf_wr_addr), .wr_data(xbuf_wr_data),
        .rd(xbuf_rd), .rd_addr(xbuf_rd_addr), .rd_data(xbuf_rd_data)
    );

    dsp_mac u_mac_l (.clk, .reset, .opmode, .a(coef), .b(samp_l), .acc(acc_l));
    dsp_mac u_mac_r (.clk, .reset, .opmode, .a(coef), .b(samp_r), .acc(acc_r));

    out_round_sat u_out (
        .clk, .reset, .acc_valid, .acc_l, .acc_r,
        .sample_out_rdy, .sample_out_l, .sample_out_r
    );

endmodule

`default_nettype wire

// File: design/out_round_sat.sv
// Output rounding and saturation
`default_nettype none

module out_round_sat (
    input  wire logic                                       clk,
    input  wire logic                                       reset,
    input  wire logic                                       acc_valid,
    input  wire logic signed [fir_decim_pkg::ACC_W-1:0]    acc_l,
    input  wire logic signed [fir_decim_pkg::ACC_W-1:0]    acc_r,
    output logic                                            sample_out_rdy,
    output logic      signed [fir_decim_pkg::SAMPLE_W-1:0] sample_out_l,
    output logic      signed [fir_decim_pkg::SAMPLE_W-1:0] sample_out_r
);

    import fir_decim_pkg::*;

    localparam logic signed [ACC_W-1:0] RND_HALF = 2 ** (OUT_SHIFT - 1);
    localparam logic signed [ACC_W-1:0] SAT_MAX  = 2 ** (SAMPLE_W - 1) - 1;
    localparam logic signed [ACC_W-1:0] SAT_MIN  = -(2 ** (SAMPLE_W - 1));

    function automatic logic signed [SAMPLE_W-1:0] round_sat(
        input logic signed [ACC_W-1:0] acc
    );
        logic signed [ACC_W-1:0] shifted;
        shifted = (acc + RND_HALF) >>> OUT_SHIFT;
        if (shifted > SAT_MAX) begin
            return SAT_MAX[SAMPLE_W-1:0];
        end else if (shifted < SAT_MIN) begin
            return SAT_MIN[SAMPLE_W-1:0];
        end
        return shifted[SAMPLE_W-1:0];
    endfunction

    // Zero between strobes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_out_rdy <= 1'b0;
            sample_out_l   <= '0;
            sample_out_r   <= '0;
        end else begin
            sample_out_rdy <= acc_valid;
            sample_out_l   <= acc_valid ? round_sat(acc_l) : '0;
            sample_out_r   <= acc_valid ? round_sat(acc_r) : '0;
        end
    end

endmodule

`default_nettype wire

// File: design/fir_decim_seq.sv
// Decimating FIR microcoded sequencer
`default_nettype none

module fir_decim_seq (
    input  wire logic                                         clk,
    input  wire logic                                         reset,
    input  wire logic                                         sample_in_rdy,
    input  wire logic signed [fir_decim_pkg::SAMPLE_W-1:0]   sample_in_l,
    input  wire logic signed [fir_decim_pkg::SAMPLE_W-1:0]   sample_in_r,
    output logic                                              xbuf_wr,
    output logic             [fir_decim_pkg::TAP_W-1:0]      xbuf_wr_addr,
    output logic             [2*fir_decim_pkg::SAMPLE_W-1:0] xbuf_wr_data,
    output logic                                              xbuf_rd,
    output logic             [fir_decim_pkg::TAP_W-1:0]      xbuf_rd_addr,
    input  wire logic        [2*fir_decim_pkg::SAMPLE_W-1:0] xbuf_rd_data,
    output logic             [fir_decim_pkg::OPMODE_W-1:0]   opmode,
    output logic      signed [fir_decim_pkg::SAMPLE_W-1:0]   coef,
    output logic      signed [fir_decim_pkg::SAMPLE_W-1:0]   samp_l,
    output logic      signed [fir_decim_pkg::SAMPLE_W-1:0]   samp_r,
    output logic                                              acc_valid,
    output logic                                              overrun,
    output logic                                              init_done
);

    import fir_decim_pkg::*;

    localparam int TASK_W = 8;
    localparam int PC_W   = 5;

    localparam logic [TASK_W-1:0] T_NOP    = 8'h00;
    localparam logic [TASK_W-1:0] T_WAIT   = 8'h01;
    localparam logic [TASK_W-1:0] T_PUSH   = 8'h02;
    localparam logic [TASK_W-1:0] T_ZERO   = 8'h04;
    localparam logic [TASK_W-1:0] T_SETUP  = 8'h08;
    localparam logic [TASK_W-1:0] T_MAC    = 8'h10;
    localparam logic [TASK_W-1:0] T_REPEAT = 8'h20;
    localparam logic [TASK_W-1:0] T_VALID  = 8'h40;
    localparam logic [TASK_W-1:0] T_JUMP   = 8'h80;

    localparam logic [PC_W-1:0]  PC_INIT       = '0;
    localparam logic [PC_W-1:0]  PC_FIRST_WAIT = PC_W'(1);
    localparam logic [PC_W-1:0]  PC_LAST_PUSH  = PC_W'(2 * DECIM);
    localparam logic [PC_W-1:0]  PC_SETUP      = PC_W'(2 * DECIM + 1);
    localparam logic [PC_W-1:0]  PC_MAC        = PC_W'(2 * DECIM + 2);
    localparam logic [PC_W-1:0]  PC_VALID      = PC_W'(2 * DECIM + 6);
    localparam logic [TAP_W-1:0] LAST_TAP      = TAP_W'(TAP_CNT - 1);

    logic [PC_W-1:0]   pc;
    logic [TASK_W-1:0] tasks;
    logic [TAP_W-1:0]  rep_cnt;
    logic [TAP_W-1:0]  head;
    logic [TAP_W-1:0]  i_idx;
    logic [TAP_W-1:0]  j_idx;
    logic              is_wait, is_push, is_zero, is_setup;
    logic              is_mac, is_repeat, is_valid, is_jump;
    logic              accept, rep_last, hold;
    logic signed [SAMPLE_W-1:0] in_l, in_r;
    logic        [OPMODE_W-1:0] op_d;
    logic signed [SAMPLE_W-1:0] coef_d;

    // ----------------------------------------------------------------------
    // Task table
    // ----------------------------------------------------------------------
    always_comb begin
        tasks = T_JUMP;
        if (pc == PC_INIT) begin
            tasks = T_REPEAT | T_PUSH | T_ZERO;
        end else if (pc <= PC_LAST_PUSH) begin
            // Odd steps wait, even steps push
            tasks = pc[0] ? T_WAIT : T_PUSH;
        end else if (pc == PC_SETUP) begin
            tasks = T_SETUP;
        end else if (pc == PC_MAC) begin
            tasks = T_REPEAT | T_MAC;
        end else if (pc < PC_VALID) begin
            tasks = T_NOP;
        end else if (pc == PC_VALID) begin
            tasks = T_VALID | T_JUMP;
        end
    end

    assign is_wait   = |(tasks & T_WAIT);
    assign is_push   = |(tasks & T_PUSH);
    assign is_zero   = |(tasks & T_ZERO);
    assign is_setup  = |(tasks & T_SETUP);
    assign is_mac    = |(tasks & T_MAC);
    assign is_repeat = |(tasks & T_REPEAT);
    assign is_valid  = |(tasks & T_VALID);
    assign is_jump   = |(tasks & T_JUMP);

    assign accept   = is_wait && sample_in_rdy;
    assign rep_last = (rep_cnt == LAST_TAP);
    assign hold     = (is_wait && !sample_in_rdy) || (is_repeat && !rep_last);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc      <= PC_INIT;
            rep_cnt <= '0;
        end else begin
            if (is_jump) begin
                pc <= PC_FIRST_WAIT;
            end else if (!hold) begin
                pc <= pc + 1'b1;
            end
            rep_cnt <= (is_repeat && !rep_last) ? rep_cnt + 1'b1 : '0;
        end
    end

    // Head walks down, j walks up from the newest sample
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head  <= '0;
            i_idx <= '0;
            j_idx <= '0;
        end else begin
            if (is_push) begin
                head <= (head == '0) ? LAST_TAP : head - 1'b1;
            end
            if (is_setup) begin
                i_idx <= '0;
                j_idx <= (head == LAST_TAP) ? '0 : head + 1'b1;
            end else if (is_mac) begin
                i_idx <= i_idx + 1'b1;
                j_idx <= (j_idx == LAST_TAP) ? '0 : j_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            in_l <= sample_in_l;
            in_r <= sample_in_r;
        end
        xbuf_wr_addr <= head;
        xbuf_wr_data <= is_zero ? '0 : {in_l, in_r};
        xbuf_rd_addr <= j_idx;
        if (is_mac) begin
            coef_d <= FIR_COEFS[i_idx];
        end
        coef <= coef_d;
    end

    // ----------------------------------------------------------------------
    // Control registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            xbuf_wr   <= 1'b0;
            xbuf_rd   <= 1'b0;
            op_d      <= OP_NOP;
            opmode    <= OP_NOP;
            acc_valid <= 1'b0;
            overrun   <= 1'b0;
            init_done <= 1'b0;
        end else begin
            xbuf_wr   <= is_push;
            xbuf_rd   <= is_mac;
            op_d      <= !is_mac ? OP_NOP : (i_idx == '0) ? OP_LOAD : OP_MAC;
            opmode    <= op_d;
            acc_valid <= is_valid;
            overrun   <= sample_in_rdy && !is_wait;
            init_done <= init_done || (is_zero && rep_last);
        end
    end

    assign samp_l = xbuf_rd_data[2*SAMPLE_W-1:SAMPLE_W];
    assign samp_r = xbuf_rd_data[SAMPLE_W-1:0];

endmodule

`default_nettype wire

// File: design/dsp_mac.sv
// DSP multiply-accumulate slice model
`default_nettype none

module dsp_mac (
    input  wire logic                                       clk,
    input  wire logic                                       reset,
    input  wire logic        [fir_decim_pkg::OPMODE_W-1:0] opmode,
    input  wire logic signed [fir_decim_pkg::SAMPLE_W-1:0] a,
    input  wire logic signed [fir_decim_pkg::SAMPLE_W-1:0] b,
    output logic      signed [fir_decim_pkg::ACC_W-1:0]    acc
);

    import fir_decim_pkg::*;

    logic        [OPMODE_W-1:0]   op_in;
    logic        [OPMODE_W-1:0]   op_prod;
    logic signed [SAMPLE_W-1:0]   a_q;
    logic signed [SAMPLE_W-1:0]   b_q;
    logic signed [2*SAMPLE_W-1:0] prod;
    logic signed [ACC_W-1:0]      prod_ext;

    // Opmode follows the data through the pipe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_in   <= OP_NOP;
            op_prod <= OP_NOP;
        end else begin
            op_in   <= opmode;
            op_prod <= op_in;
        end
    end

    always_ff @(posedge clk) begin
        a_q  <= a;
        b_q  <= b;
        prod <= a_q * b_q;
    end

    assign prod_ext = prod;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc <= '0;
        end else begin
            case (op_prod)
                OP_LOAD: acc <= prod_ext;
                OP_MAC:  acc <= acc + prod_ext;
                default: acc <= acc;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/dp_ram.sv
// Simple dual-port delay-line RAM
`default_nettype none

module dp_ram #(
    parameter int DATA_W = 36,
    parameter int ADDR_W = 6,
    parameter int DEPTH  = 34
) (
    input  wire logic              clk,
    input  wire logic              wr,
    input  wire logic [ADDR_W-1:0] wr_addr,
    input  wire logic [DATA_W-1:0] wr_data,
    input  wire logic              rd,
    input  wire logic [ADDR_W-1:0] rd_addr,
    output logic      [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, holds when rd is low
    always_ff @(posedge clk) begin
        if (rd) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: design/fir_decim_pkg.sv
// Decimating FIR shared definitions
`default_nettype none

package fir_decim_pkg;

    // Data path widths
    localparam int SAMPLE_W  = 18;
    localparam int ACC_W     = 48;

    // Filter geometry
    localparam int TAP_CNT   = 34;
    localparam int TAP_W     = 6;
    localparam int DECIM     = 8;

    // Accumulator to output scaling
    localparam int OUT_SHIFT = 16;

    // DSP slice opmodes
    localparam int OPMODE_W  = 2;
    localparam logic [OPMODE_W-1:0] OP_NOP  = 2'd0;
    localparam logic [OPMODE_W-1:0] OP_LOAD = 2'd1;
    localparam logic [OPMODE_W-1:0] OP_MAC  = 2'd2;

    // ----------------------------------------------------------------------
    // Symmetric low-pass taps, 384 kHz to 48 kHz
    // ----------------------------------------------------------------------
    localparam logic signed [SAMPLE_W-1:0] FIR_COEFS [TAP_CNT] = '{
        18'sh00002, 18'sh3FFF6, 18'sh0001A, 18'sh3FFC5,
        18'sh00071, 18'sh3FF36, 18'sh0014E, 18'sh3FDEF,
        18'sh00322, 18'sh3FB62, 18'sh006A5, 18'sh3F68B,
        18'sh00D71, 18'sh3EC88, 18'sh01DC3, 18'sh3CB6A,
        18'sh0A263,
        18'sh0A263,
        18'sh3CB6A, 18'sh01DC3, 18'sh3EC88, 18'sh00D71,
        18'sh3F68B, 18'sh006A5, 18'sh3FB62, 18'sh00322,
        18'sh3FDEF, 18'sh0014E, 18'sh3FF36, 18'sh00071,
        18'sh3FFC5, 18'sh0001A, 18'sh3FFF6, 18'sh00002
    };

endpackage

`default_nettype wire
